/* hdl/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry
    parameter int INDEX_WIDTH       = 4;
    parameter int WORD_OFFSET_WIDTH = 2;
    parameter int NUM_WAYS          = 2;
    parameter int NUM_SETS          = 1 << INDEX_WIDTH;
    parameter int LINE_BYTES        = 1 << (WORD_OFFSET_WIDTH + 2);
    parameter int LINE_BITS         = LINE_BYTES * 8;
    parameter int TAG_WIDTH         = 32 - INDEX_WIDTH - WORD_OFFSET_WIDTH - 2;

    typedef logic [LINE_BITS-1:0] line_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]         tag;
        logic [INDEX_WIDTH-1:0]       index;
        logic [WORD_OFFSET_WIDTH-1:0] word;
        logic [1:0]                   byte_sel;   // byte within the word
    } addr_fields_t;

    // one address word, seen raw or split for the arrays
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t fields;
    } addr_u;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } size_e;

    typedef struct packed {
        logic        is_write;
        size_e       size;
        logic        signed_ext;
        addr_u       addr;
        logic [31:0] wdata;
    } req_t;

    typedef struct packed {
        logic                  line_we;     // whole line plus tag
        logic [LINE_BYTES-1:0] byte_we;     // write hit bytes
        line_t                 wline;
        logic                  set_dirty;
        logic                  clr_dirty;
    } way_ctrl_t;

    typedef struct packed {
        logic                 hit;
        logic                 valid;
        logic                 dirty;
        logic [TAG_WIDTH-1:0] tag;
        line_t                line;
    } way_status_t;

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        LOOKUP     = 3'd1,
        WRITEBACK  = 3'd2,
        REFILL_REQ = 3'd3,
        REFILL     = 3'd4,
        RESPOND    = 3'd5
    } state_e;

endpackage

/* hdl/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                              clk,
    input  logic                                              rstn,
    input  logic                                              i_rvalid,
    input  logic                                              i_wvalid,
    input  logic [31:0]                                       i_addr,
    input  logic [31:0]                                       i_wdata,
    input  dcache_pkg::size_e                                 i_size,
    input  logic                                              i_signed_ext,
    input  logic                                              i_hit,
    input  logic                                              i_hit_way,
    input  logic                                              i_victim_way,
    input  logic                                              i_victim_dirty,
    input  logic                                              i_mem_rd_ready,
    input  dcache_pkg::line_t                                 i_mem_rd_data,
    input  logic                                              i_mem_wr_ready,
    output dcache_pkg::req_t                                  o_req,
    output dcache_pkg::way_ctrl_t [dcache_pkg::NUM_WAYS-1:0]  o_way_ctrl,
    output logic                                              o_rready,
    output logic                                              o_wready,
    output logic                                              o_idle,
    output logic                                              o_mem_rd_valid,
    output logic [31:0]                                       o_mem_rd_addr,
    output logic                                              o_mem_wr_valid,
    output logic                                              o_lru_we,
    output logic                                              o_lru_way
);
    import dcache_pkg::*;

    state_e                state;
    state_e                next_state;
    req_t                  req_q;
    line_t                 refill_q;     // line returned by memory
    logic [3:0]            word_mask;
    logic [LINE_BYTES-1:0] line_mask;
    line_t                 bit_mask;
    line_t                 store_line;
    line_t                 merged_line;
    line_t                 wr_line;
    addr_u                 rd_addr;
    logic                  hit_write;

    // request buffer is loaded only from IDLE
    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_q <= '0;
        end else if (state == IDLE && (i_rvalid || i_wvalid)) begin
            req_q.is_write   <= i_wvalid;
            req_q.size       <= i_size;
            req_q.signed_ext <= i_signed_ext;
            req_q.addr.raw   <= i_addr;
            req_q.wdata      <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (state == REFILL_REQ && i_mem_rd_ready) begin
            refill_q <= i_mem_rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (i_rvalid || i_wvalid) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (i_hit) begin
                    next_state = IDLE;
                end else begin
                    next_state = i_victim_dirty ? WRITEBACK : REFILL_REQ;
                end
            end
            WRITEBACK: begin
                if (i_mem_wr_ready) begin
                    next_state = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                if (i_mem_rd_ready) begin
                    next_state = REFILL;
                end
            end
            REFILL:  next_state = RESPOND;
            RESPOND: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // byte lanes touched by the store
    always_comb begin
        case (req_q.size)
            SZ_BYTE: word_mask = 4'b0001 << req_q.addr.fields.byte_sel;
            SZ_HALF: word_mask = 4'b0011 << req_q.addr.fields.byte_sel;
            default: word_mask = 4'b1111;
        endcase
    end

    assign line_mask = LINE_BYTES'(word_mask) << {req_q.addr.fields.word, 2'b00};
    assign store_line = LINE_BITS'(req_q.wdata << {req_q.addr.fields.byte_sel, 3'b000})
                        << {req_q.addr.fields.word, 5'b00000};

    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            bit_mask[8*b +: 8] = {8{line_mask[b]}};
        end
    end

    // store data lands on top of the refilled line
    assign merged_line = req_q.is_write ? (refill_q & ~bit_mask) | (store_line & bit_mask)
                                        : refill_q;
    assign wr_line   = (state == REFILL) ? merged_line : store_line;
    assign hit_write = (state == LOOKUP) && i_hit && req_q.is_write;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            o_way_ctrl[w].line_we   = (state == REFILL) && (i_victim_way == w);
            o_way_ctrl[w].byte_we   = (hit_write && i_hit_way == w) ? line_mask : '0;
            o_way_ctrl[w].wline     = wr_line;
            o_way_ctrl[w].set_dirty = (hit_write && i_hit_way == w)
                                      || (o_way_ctrl[w].line_we && req_q.is_write);
            o_way_ctrl[w].clr_dirty = o_way_ctrl[w].line_we && !req_q.is_write;
        end
    end

    // refill address is the request line
    always_comb begin
        rd_addr                 = req_q.addr;
        rd_addr.fields.word     = '0;
        rd_addr.fields.byte_sel = '0;
    end

    assign o_mem_rd_addr  = rd_addr.raw;
    assign o_mem_rd_valid = (state == REFILL_REQ);
    assign o_mem_wr_valid = (state == WRITEBACK);

    assign o_rready = ((state == LOOKUP && i_hit) || state == RESPOND) && !req_q.is_write;
    assign o_wready = ((state == LOOKUP && i_hit) || state == RESPOND) && req_q.is_write;
    assign o_idle   = (state == IDLE);
    assign o_req    = req_q;

    assign o_lru_we  = (state == LOOKUP && i_hit) || (state == REFILL);
    assign o_lru_way = (state == REFILL) ? i_victim_way : i_hit_way;

    mem_excl_a: assert property (@(posedge clk) disable iff (!rstn)
        !(o_mem_rd_valid && o_mem_wr_valid));

endmodule

/* hdl/cache_way.sv */
`timescale 1ns/1ps

module cache_way (
    input  logic                             clk,
    input  logic                             rstn,
    input  dcache_pkg::req_t                 i_req,
    input  dcache_pkg::way_ctrl_t            i_ctrl,
    input  logic [dcache_pkg::TAG_WIDTH-1:0] i_refill_tag,
    output dcache_pkg::way_status_t          o_status
);
    import dcache_pkg::*;

    logic [TAG_WIDTH-1:0]   tag_mem  [NUM_SETS];
    line_t                  data_mem [NUM_SETS];
    logic [NUM_SETS-1:0]    valid_q;
    logic [NUM_SETS-1:0]    dirty_q;
    logic [INDEX_WIDTH-1:0] idx;

    assign idx = i_req.addr.fields.index;   // buffered index only

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (i_ctrl.line_we) begin
            tag_mem[idx]  <= i_refill_tag;
            data_mem[idx] <= i_ctrl.wline;
        end else begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (i_ctrl.byte_we[b]) begin
                    data_mem[idx][8*b +: 8] <= i_ctrl.wline[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (i_ctrl.line_we) begin
                valid_q[idx] <= 1'b1;
            end
            if (i_ctrl.set_dirty) begin
                dirty_q[idx] <= 1'b1;
            end else if (i_ctrl.clr_dirty) begin
                dirty_q[idx] <= 1'b0;   // clean refill
            end
        end
    end

    always_comb begin
        o_status.valid = valid_q[idx];
        o_status.dirty = dirty_q[idx];
        o_status.tag   = tag_mem[idx];
        o_status.line  = data_mem[idx];
        o_status.hit   = valid_q[idx] && (tag_mem[idx] == i_req.addr.fields.tag);
    end

    // byte writes only ever go to a valid way that hits
    hit_write_a: assert property (@(posedge clk) disable iff (!rstn)
        (|i_ctrl.byte_we) |-> o_status.hit && o_status.valid);

    // a refilled line hits on the held request one cycle later
    refill_hit_a: assert property (@(posedge clk) disable iff (!rstn)
        i_ctrl.line_we |=> o_status.hit);

endmodule

/* hdl/way_select.sv */
`timescale 1ns/1ps

module way_select (
    input  logic                                                clk,
    input  logic                                                rstn,
    input  dcache_pkg::req_t                                    i_req,
    input  dcache_pkg::way_status_t [dcache_pkg::NUM_WAYS-1:0]  i_status,
    input  logic                                                i_lru_we,
    input  logic                                                i_lru_way,
    output logic                                                o_hit,
    output logic                                                o_hit_way,
    output logic                                                o_victim_way,
    output logic                                                o_victim_dirty,
    output logic [31:0]                                         o_rdata,
    output logic [31:0]                                         o_mem_wr_addr,
    output dcache_pkg::line_t                                   o_mem_wr_data
);
    import dcache_pkg::*;

    logic [NUM_SETS-1:0]    lru_q;      // way to replace next, per set
    logic [INDEX_WIDTH-1:0] idx;
    logic [NUM_WAYS-1:0]    hits;
    line_t                  hit_line;
    logic [31:0]            rword;
    logic [7:0]             rbyte;
    logic [15:0]            rhalf;
    addr_u                  wb_addr;

    assign idx = i_req.addr.fields.index;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hits[w] = i_status[w].hit;
        end
    end

    assign o_hit     = |hits;
    assign o_hit_way = hits[1];

    // LRU table
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (i_lru_we) begin
            lru_q[idx] <= ~i_lru_way;   // the other way becomes LRU
        end
    end

    // empty ways fill first
    always_comb begin
        if (!i_status[0].valid) begin
            o_victim_way = 1'b0;
        end else if (!i_status[1].valid) begin
            o_victim_way = 1'b1;
        end else begin
            o_victim_way = lru_q[idx];
        end
    end

    assign o_victim_dirty = i_status[o_victim_way].dirty;

    // load data
    assign hit_line = i_status[o_hit_way].line;
    assign rword    = hit_line[{i_req.addr.fields.word, 5'b00000} +: 32];
    assign rbyte    = rword[{i_req.addr.fields.byte_sel, 3'b000} +: 8];
    assign rhalf    = i_req.addr.fields.byte_sel[1] ? rword[31:16] : rword[15:0];

    always_comb begin
        case (i_req.size)
            SZ_BYTE: o_rdata = {{24{rbyte[7] & i_req.signed_ext}}, rbyte};
            SZ_HALF: o_rdata = {{16{rhalf[15] & i_req.signed_ext}}, rhalf};
            default: o_rdata = rword;
        endcase
    end

    // write-back line address from the victim tag
    always_comb begin
        wb_addr.fields.tag      = i_status[o_victim_way].tag;
        wb_addr.fields.index    = idx;
        wb_addr.fields.word     = '0;
        wb_addr.fields.byte_sel = '0;
    end

    assign o_mem_wr_addr = wb_addr.raw;
    assign o_mem_wr_data = i_status[o_victim_way].line;

    // one line per set and address, so both ways never match
    one_hit_a: assert property (@(posedge clk) disable iff (!rstn)
        !(i_status[0].hit && i_status[1].hit));

endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_rvalid,
    input  logic               i_wvalid,
    input  logic [31:0]        i_addr,
    input  logic [31:0]        i_wdata,
    input  dcache_pkg::size_e  i_size,
    input  logic               i_signed_ext,
    output logic               o_rready,
    output logic               o_wready,
    output logic [31:0]        o_rdata,
    output logic               o_idle,
    output logic               o_mem_rd_valid,
    output logic [31:0]        o_mem_rd_addr,
    input  logic               i_mem_rd_ready,
    input  dcache_pkg::line_t  i_mem_rd_data,
    output logic               o_mem_wr_valid,
    output logic [31:0]        o_mem_wr_addr,
    output dcache_pkg::line_t  o_mem_wr_data,
    input  logic               i_mem_wr_ready
);
    import dcache_pkg::*;

    req_t                        req;
    way_ctrl_t   [NUM_WAYS-1:0]  way_ctrl;
    way_status_t [NUM_WAYS-1:0]  way_status;
    logic                        hit;
    logic                        hit_way;
    logic                        victim_way;
    logic                        victim_dirty;
    logic                        lru_we;
    logic                        lru_way;

    dcache_ctrl i_dcache_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .i_rvalid       (i_rvalid),
        .i_wvalid       (i_wvalid),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .i_size         (i_size),
        .i_signed_ext   (i_signed_ext),
        .i_hit          (hit),
        .i_hit_way      (hit_way),
        .i_victim_way   (victim_way),
        .i_victim_dirty (victim_dirty),
        .i_mem_rd_ready (i_mem_rd_ready),
        .i_mem_rd_data  (i_mem_rd_data),
        .i_mem_wr_ready (i_mem_wr_ready),
        .o_req          (req),
        .o_way_ctrl     (way_ctrl),
        .o_rready       (o_rready),
        .o_wready       (o_wready),
        .o_idle         (o_idle),
        .o_mem_rd_valid (o_mem_rd_valid),
        .o_mem_rd_addr  (o_mem_rd_addr),
        .o_mem_wr_valid (o_mem_wr_valid),
        .o_lru_we       (lru_we),
        .o_lru_way      (lru_way)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way i_cache_way (
            .clk          (clk),
            .rstn         (rstn),
            .i_req        (req),
            .i_ctrl       (way_ctrl[w]),
            .i_refill_tag (req.addr.fields.tag),
            .o_status     (way_status[w])
        );
    end

    way_select i_way_select (
        .clk            (clk),
        .rstn           (rstn),
        .i_req          (req),
        .i_status       (way_status),
        .i_lru_we       (lru_we),
        .i_lru_way      (lru_way),
        .o_hit          (hit),
        .o_hit_way      (hit_way),
        .o_victim_way   (victim_way),
        .o_victim_dirty (victim_dirty),
        .o_rdata        (o_rdata),
        .o_mem_wr_addr  (o_mem_wr_addr),
        .o_mem_wr_data  (o_mem_wr_data)
    );

endmodule

/* bench/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    typedef struct packed {
        logic        is_write;
        logic [1:0]  size;
        logic        signed_ext;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        miss;
        logic        has_wb;
        logic [31:0] wb_addr;
    } access_t;

    logic        clk;
    logic        rstn;
    logic        i_rvalid;
    logic        i_wvalid;
    logic [31:0] i_addr;
    logic [31:0] i_wdata;
    size_e       i_size;
    logic        i_signed_ext;
    logic        o_rready;
    logic        o_wready;
    logic [31:0] o_rdata;
    logic        o_idle;
    logic        o_mem_rd_valid;
    logic [31:0] o_mem_rd_addr;
    logic        i_mem_rd_ready;
    line_t       i_mem_rd_data;
    logic        o_mem_wr_valid;
    logic [31:0] o_mem_wr_addr;
    line_t       o_mem_wr_data;
    logic        i_mem_wr_ready;

    access_t     accesses[$];
    line_t       mem_lines[logic [31:0]];   // lines written back by the DUT
    int unsigned delays[64];
    int unsigned dly_ptr;
    int unsigned rd_wait;
    int unsigned wr_wait;
    int unsigned cycle_cnt;
    int unsigned limit;
    int unsigned checks;
    int unsigned errors;
    logic        rd_seen;
    logic        wb_seen;
    logic [31:0] wb_addr_seen;
    logic [31:0] cur_line;

    dcache_top i_dcache_top (.*);

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic pick_delay(output int unsigned d);
        d = delays[dly_ptr];
        dly_ptr = (dly_ptr + 1) % 64;
    endtask

    // untouched memory holds its own byte address xor a constant
    function automatic line_t fill_line(input logic [31:0] line_addr);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[32*k +: 32] = (line_addr + 4 * k) ^ 32'h5a5a0000;
        end
        return l;
    endfunction

    function automatic line_t read_line(input logic [31:0] line_addr);
        if (mem_lines.exists(line_addr)) begin
            return mem_lines[line_addr];
        end
        return fill_line(line_addr);
    endfunction

    // memory model with a short random wait before ready
    always @(negedge clk) begin
        i_mem_rd_ready <= 1'b0;
        i_mem_wr_ready <= 1'b0;
        if (rstn && o_mem_rd_valid && !i_mem_rd_ready) begin
            rd_seen = 1'b1;
            if (rd_wait == 0) begin
                check_value("o_mem_rd_addr", cur_line, o_mem_rd_addr);
                i_mem_rd_ready <= 1'b1;
                i_mem_rd_data  <= read_line(o_mem_rd_addr);
                pick_delay(rd_wait);
            end else begin
                rd_wait--;
            end
        end
        if (rstn && o_mem_wr_valid && !i_mem_wr_ready) begin
            if (wr_wait == 0) begin
                wb_seen = 1'b1;
                wb_addr_seen = o_mem_wr_addr;
                mem_lines[o_mem_wr_addr] = o_mem_wr_data;
                i_mem_wr_ready <= 1'b1;
                pick_delay(wr_wait);
            end else begin
                wr_wait--;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (limit != 0 && cycle_cnt > limit) begin
            $display("timeout after %0d cycles, DUT stopped responding", cycle_cnt);
            $display("checks %0d errors %0d", checks, errors + 1);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic load_trace();
        int          fd;
        int          n;
        int          size;
        int          sgn;
        int          miss;
        string       text;
        string       op;
        string       wb_text;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] wb;
        access_t     a;
        fd = $fopen("bench/dcache_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("trace file bench/dcache_trace.txt could not be opened");
            return;
        end
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            if (n == 0 || text.len() < 2 || text.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(text, "%s %d %d %h %h %h %d %s", op, size, sgn, addr, wdata,
                        rdata, miss, wb_text);
            if (n != 8) begin
                errors++;
                $display("trace line could not be parsed: %s", text);
                continue;
            end
            a.is_write   = (op == "W");
            a.size       = size[1:0];
            a.signed_ext = sgn[0];
            a.addr       = addr;
            a.wdata      = wdata;
            a.rdata      = rdata;
            a.miss       = miss[0];
            a.has_wb     = (wb_text != "none");
            wb           = '0;
            if (a.has_wb) begin
                n = $sscanf(wb_text, "%h", wb);
            end
            a.wb_addr = wb;
            accesses.push_back(a);
        end
        $fclose(fd);
    endtask

    task automatic run_access(input access_t t, input int idx);
        int unsigned waits;
        waits = 0;
        @(negedge clk);
        assert (o_idle) else begin
            errors++;
            $display("DUT was not idle before access %0d", idx);
        end
        rd_seen  = 1'b0;
        wb_seen  = 1'b0;
        cur_line = {t.addr[31:4], 4'h0};
        i_rvalid     <= !t.is_write;
        i_wvalid     <= t.is_write;
        i_addr       <= t.addr;
        i_wdata      <= t.wdata;
        i_size       <= size_e'(t.size);
        i_signed_ext <= t.signed_ext;
        do begin
            @(negedge clk);
            waits++;
        end while (!(o_rready || o_wready));
        check_value("o_rready", !t.is_write, o_rready);
        check_value("o_wready", t.is_write, o_wready);
        if (!t.is_write) begin
            check_value("o_rdata", t.rdata, o_rdata);
        end
        check_value("o_mem_rd_valid", t.miss, rd_seen);
        check_value("o_mem_wr_valid", t.has_wb, wb_seen);
        if (t.has_wb && wb_seen) begin
            check_value("o_mem_wr_addr", t.wb_addr, wb_addr_seen);
        end
        if (!t.miss) begin
            check_value("hit latency", 1, waits);   // ready in the LOOKUP cycle
        end
        i_rvalid <= 1'b0;
        i_wvalid <= 1'b0;
    endtask

    initial begin
        clk            = 1'b0;
        rstn           = 1'b0;
        i_rvalid       = 1'b0;
        i_wvalid       = 1'b0;
        i_addr         = '0;
        i_wdata        = '0;
        i_size         = SZ_WORD;
        i_signed_ext   = 1'b0;
        i_mem_rd_ready = 1'b0;
        i_mem_rd_data  = '0;
        i_mem_wr_ready = 1'b0;
        rd_seen        = 1'b0;
        wb_seen        = 1'b0;
        wb_addr_seen   = '0;
        cur_line       = '0;
        void'($urandom(84962));
        for (int i = 0; i < 64; i++) begin
            delays[i] = $urandom % 4;
        end
        pick_delay(rd_wait);
        pick_delay(wr_wait);
        load_trace();
        limit = accesses.size() * 40;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_value("o_idle", 1'b1, o_idle);
        check_value("o_rready", 1'b0, o_rready);
        check_value("o_wready", 1'b0, o_wready);
        check_value("o_mem_rd_valid", 1'b0, o_mem_rd_valid);
        check_value("o_mem_wr_valid", 1'b0, o_mem_wr_valid);
        foreach (accesses[i]) begin
            run_access(accesses[i], i);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* bench/dcache_trace.txt */
# op R/W, size 0 byte 1 half 2 word, signed, addr, wdata, expected rdata (hex)
# miss 1 when a refill is expected, then the write-back line address or none
R 2 0 00001010 00000000 5a5a1010 1 none
R 2 0 00001014 00000000 5a5a1014 0 none
R 2 0 0000101c 00000000 5a5a101c 0 none
R 0 0 0000a080 00000000 00000080 1 none
R 0 1 0000a080 00000000 ffffff80 0 none
R 0 1 0000a081 00000000 ffffffa0 0 none
R 0 1 0000a082 00000000 0000005a 0 none
R 0 0 0000a083 00000000 0000005a 0 none
R 1 1 0000a080 00000000 ffffa080 0 none
R 1 0 0000a080 00000000 0000a080 0 none
R 1 1 0000a082 00000000 00005a5a 0 none
R 0 1 c0000043 00000000 ffffff9a 1 none
R 0 0 c0000043 00000000 0000009a 0 none
R 1 1 c0000042 00000000 ffff9a5a 0 none
R 1 0 c0000042 00000000 00009a5a 0 none
R 0 1 c0000040 00000000 00000040 0 none
R 1 1 c000004e 00000000 ffff9a5a 0 none
W 0 0 00001019 000000ab 00000000 0 none
R 2 0 00001018 00000000 5a5aab18 0 none
W 1 0 0000101a 0000beef 00000000 0 none
R 2 0 00001018 00000000 beefab18 0 none
W 2 0 00001014 12345678 00000000 0 none
R 2 0 00001014 00000000 12345678 0 none
R 1 1 00001016 00000000 00001234 0 none
R 2 0 00001010 00000000 5a5a1010 0 none
R 2 0 00002010 00000000 5a5a2010 1 none
R 2 0 00001010 00000000 5a5a1010 0 none
R 2 0 00003010 00000000 5a5a3010 1 none
R 2 0 00001010 00000000 5a5a1010 0 none
R 2 0 00002014 00000000 5a5a2014 1 none
R 2 0 00003018 00000000 5a5a3018 1 00001010
R 2 0 00001014 00000000 12345678 1 none
R 2 0 00001018 00000000 beefab18 0 none
R 2 0 00001010 00000000 5a5a1010 0 none
W 2 0 00004024 cafef00d 00000000 1 none
R 2 0 00004024 00000000 cafef00d 0 none
R 2 0 00004028 00000000 5a5a4028 0 none
W 0 0 00005022 00000077 00000000 1 none
R 2 0 00005020 00000000 5a775020 0 none
R 2 0 00006020 00000000 5a5a6020 1 00004020
R 2 0 00004024 00000000 cafef00d 1 00005020
R 2 0 00005020 00000000 5a775020 1 none
R 0 1 00005022 00000000 00000077 0 none

/* tb.f */
hdl/dcache_pkg.sv
hdl/dcache_ctrl.sv
hdl/cache_way.sv
hdl/way_select.sv
hdl/dcache_top.sv
bench/tb_dcache.sv
